// ==== logic/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam logic [3:0] DEV_TYPE = 4'b1010;   // 24Cxx device type code
    localparam int         ADDR_W   = 11;        // 2 KB array

    // byte level operations from sequencer to byte engine
    typedef enum logic [1:0] {
        OP_START,   // start or repeated start
        OP_STOP,
        OP_SEND,    // byte out then slave ack in
        OP_RECV     // byte in then master ack out
    } byte_op_t;

    // bit level symbols from byte engine to line driver
    typedef enum logic [1:0] {
        SYM_START,
        SYM_STOP,
        SYM_WRITE,  // drive one bit
        SYM_READ    // release sda and sample
    } sym_t;

    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] block;      // address bits 10..8
        logic       rw;         // 1 for read
    } ctrl_fields_t;

    // control byte, built from fields and sent as a raw byte
    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t fields;
    } ctrl_byte_u;

endpackage

// ==== logic/i2c_byte_if.sv ====
`timescale 1ns/1ps

interface i2c_byte_if import eeprom_pkg::*; ();

    logic       op_strobe;
    byte_op_t   op;
    logic [7:0] tx_byte;
    logic       master_nack;   // ack level sent after OP_RECV
    logic       op_done;
    logic [7:0] rx_byte;
    logic       slave_nack;    // valid with op_done

    modport seq (
        output op_strobe, op, tx_byte, master_nack,
        input  op_done, rx_byte, slave_nack
    );

    modport eng (
        input  op_strobe, op, tx_byte, master_nack,
        output op_done, rx_byte, slave_nack
    );

endinterface

// ==== logic/i2c_bit_if.sv ====
`timescale 1ns/1ps

interface i2c_bit_if import eeprom_pkg::*; ();

    logic sym_strobe;
    sym_t sym;
    logic tx_bit;
    logic sym_done;
    logic rx_bit;     // valid with sym_done

    modport eng (
        output sym_strobe, sym, tx_bit,
        input  sym_done, rx_bit
    );

    modport phy (
        input  sym_strobe, sym, tx_bit,
        output sym_done, rx_bit
    );

endinterface

// ==== logic/eeprom_sequencer.sv ====
`timescale 1ns/1ps

module eeprom_sequencer import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata,
    output logic              done,
    output logic              err,
    output logic              busy,
    i2c_byte_if.seq           bif
);

    localparam logic [3:0] ST_IDLE    = 4'd0;
    localparam logic [3:0] ST_START   = 4'd1;
    localparam logic [3:0] ST_CTRL_W  = 4'd2;
    localparam logic [3:0] ST_ADDR    = 4'd3;
    localparam logic [3:0] ST_DATA    = 4'd4;
    localparam logic [3:0] ST_RESTART = 4'd5;
    localparam logic [3:0] ST_CTRL_R  = 4'd6;
    localparam logic [3:0] ST_RECV    = 4'd7;
    localparam logic [3:0] ST_STOP    = 4'd8;

    logic [3:0]        state;
    logic [3:0]        next_state;
    logic              wait_q;       // op issued, waiting for op_done
    logic              is_read;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        wdata_q;
    logic [7:0]        rx_q;
    logic              accept;
    logic              nack_abort;
    ctrl_byte_u        ctrl;

    assign accept     = (state == ST_IDLE) && (wr || rd);
    assign nack_abort = (bif.op == OP_SEND) && bif.slave_nack;

    // operation for the current state, held stable while it runs
    always_comb
    begin
        ctrl.fields.dev_type = DEV_TYPE;
        ctrl.fields.block    = addr_q[ADDR_W-1 -: 3];
        ctrl.fields.rw       = (state == ST_CTRL_R);
        bif.master_nack      = (state == ST_RECV);   // single byte read
        case (state)
            ST_START, ST_RESTART: bif.op = OP_START;
            ST_RECV:              bif.op = OP_RECV;
            ST_STOP, ST_IDLE:     bif.op = OP_STOP;
            default:              bif.op = OP_SEND;
        endcase
        case (state)
            ST_ADDR: bif.tx_byte = addr_q[7:0];
            ST_DATA: bif.tx_byte = wdata_q;
            default: bif.tx_byte = ctrl.raw;
        endcase
    end

    always_comb
    begin
        case (state)
            ST_START:   next_state = ST_CTRL_W;
            ST_CTRL_W:  next_state = ST_ADDR;
            ST_ADDR:    next_state = is_read ? ST_RESTART : ST_DATA;
            ST_RESTART: next_state = ST_CTRL_R;
            ST_CTRL_R:  next_state = ST_RECV;
            ST_STOP:    next_state = ST_IDLE;
            default:    next_state = ST_STOP;   // data byte or read byte
        endcase
        if (nack_abort)
            next_state = ST_STOP;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= ST_IDLE;
            wait_q        <= 1'b0;
            bif.op_strobe <= 1'b0;
            done          <= 1'b0;
            err           <= 1'b0;
            busy          <= 1'b0;
        end
        else
        begin
            bif.op_strobe <= 1'b0;
            done          <= 1'b0;
            if (state == ST_IDLE)
            begin
                if (accept)
                begin
                    state <= ST_START;
                    busy  <= 1'b1;
                    err   <= 1'b0;
                end
            end
            else if (!wait_q)
            begin
                bif.op_strobe <= 1'b1;
                wait_q        <= 1'b1;
            end
            else if (bif.op_done)
            begin
                wait_q <= 1'b0;
                state  <= next_state;
                if (nack_abort)
                    err <= 1'b1;
                if (state == ST_STOP)
                begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_read <= !wr;   // wr wins over rd
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (bif.op_done && state == ST_RECV)
            rx_q <= bif.rx_byte;
        if (bif.op_done && state == ST_STOP && is_read && !err)
            rdata <= rx_q;
    end

endmodule

// ==== logic/i2c_byte_engine.sv ====
`timescale 1ns/1ps

module i2c_byte_engine import eeprom_pkg::*; (
    input  logic    CLK,
    input  logic    RESET,
    i2c_byte_if.eng bif,
    i2c_bit_if.eng  pif
);

    logic       run;       // byte op in progress
    logic       issue;     // send next symbol
    logic [3:0] bit_cnt;   // symbol index within the op
    logic [7:0] shreg;
    byte_op_t   op_q;
    logic       mnack_q;
    logic       last_sym;
    sym_t       sym_next;
    logic       tx_next;

    assign bif.rx_byte = shreg;
    assign last_sym    = (op_q == OP_START) || (op_q == OP_STOP) || (bit_cnt == 4'd8);

    always_comb
    begin
        case (op_q)
            OP_START: sym_next = SYM_START;
            OP_STOP:  sym_next = SYM_STOP;
            OP_SEND:  sym_next = (bit_cnt == 4'd8) ? SYM_READ : SYM_WRITE;
            default:  sym_next = (bit_cnt == 4'd8) ? SYM_WRITE : SYM_READ;
        endcase
        tx_next = (op_q == OP_SEND) ? shreg[7] : mnack_q;   // msb first
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            run            <= 1'b0;
            issue          <= 1'b0;
            pif.sym_strobe <= 1'b0;
            bif.op_done    <= 1'b0;
        end
        else
        begin
            pif.sym_strobe <= 1'b0;
            bif.op_done    <= 1'b0;
            if (bif.op_strobe)
            begin
                run   <= 1'b1;
                issue <= 1'b1;
            end
            else if (issue)
            begin
                issue          <= 1'b0;
                pif.sym_strobe <= 1'b1;
            end
            else if (run && pif.sym_done)
            begin
                if (last_sym)
                begin
                    run         <= 1'b0;
                    bif.op_done <= 1'b1;
                end
                else
                    issue <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bif.op_strobe)
        begin
            op_q    <= bif.op;
            shreg   <= bif.tx_byte;
            mnack_q <= bif.master_nack;
            bit_cnt <= 4'd0;
        end
        else if (issue)
        begin
            pif.sym    <= sym_next;
            pif.tx_bit <= tx_next;
        end
        else if (run && pif.sym_done)
        begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt < 4'd8)
                shreg <= {shreg[6:0], pif.rx_bit};
            if (last_sym)
                bif.slave_nack <= (op_q == OP_SEND) && pif.rx_bit;   // ack bit high
        end
    end

endmodule

// ==== logic/i2c_line_phy.sv ====
`timescale 1ns/1ps

module i2c_line_phy import eeprom_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic   CLK,
    input  logic   RESET,
    i2c_bit_if.phy pif,
    output logic   scl,
    inout  wire    sda
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       phase;      // quarter of the scl period
    logic             active;
    logic             quarter_end;
    logic             sda_rel;    // 1 releases sda
    sym_t             sym_q;
    logic             bit_q;

    // {scl, sda released} for one quarter of a symbol
    function automatic logic [1:0] lines(sym_t s, logic b, logic [1:0] p);
        logic clk_hi;
        clk_hi = (p == 2'd1) || (p == 2'd2);
        case (s)
            SYM_START: lines = {clk_hi, ~p[1]};        // sda falls while scl high
            SYM_STOP:  lines = {p != 2'd0, p[1]};      // sda rises while scl high
            SYM_WRITE: lines = {clk_hi, b};
            default:   lines = {clk_hi, 1'b1};
        endcase
    endfunction

    assign quarter_end  = active && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign pif.sym_done = quarter_end && (phase == 2'd3);
    assign sda          = sda_rel ? 1'bz : 1'b0;   // open drain

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            div_cnt <= '0;
            phase   <= 2'd0;
            scl     <= 1'b1;
            sda_rel <= 1'b1;
        end
        else if (pif.sym_strobe)
        begin
            active         <= 1'b1;
            div_cnt        <= '0;
            phase          <= 2'd0;
            {scl, sda_rel} <= lines(pif.sym, pif.tx_bit, 2'd0);
        end
        else if (active)
        begin
            if (quarter_end)
            begin
                div_cnt <= '0;
                phase   <= phase + 2'd1;
                if (phase == 2'd3)
                    active <= 1'b0;   // lines hold until next symbol
                else
                    {scl, sda_rel} <= lines(sym_q, bit_q, phase + 2'd1);
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pif.sym_strobe)
        begin
            sym_q <= pif.sym;
            bit_q <= pif.tx_bit;
        end
        if (quarter_end && phase == 2'd2)
            pif.rx_bit <= sda;   // end of scl high
    end

endmodule

// ==== logic/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_top import eeprom_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata,
    output logic              done,
    output logic              err,
    output logic              busy,
    output logic              scl,
    inout  wire               sda
);

    i2c_byte_if bif ();
    i2c_bit_if  pif ();

    eeprom_sequencer u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .busy  (busy),
        .bif   (bif.seq)
    );

    i2c_byte_engine u_eng (
        .CLK   (CLK),
        .RESET (RESET),
        .bif   (bif.eng),
        .pif   (pif.eng)
    );

    i2c_line_phy #(
        .CLK_DIV (CLK_DIV)
    ) u_phy (
        .CLK   (CLK),
        .RESET (RESET),
        .pif   (pif.phy),
        .scl   (scl),
        .sda   (sda)
    );

endmodule

// ==== test/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*; (
    input  wire scl,
    inout  wire sda,
    input  wire ack_en    // low withholds every acknowledge
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_CTRL  = 3'd1;
    localparam logic [2:0] S_ADDR  = 3'd2;
    localparam logic [2:0] S_WDATA = 3'd3;
    localparam logic [2:0] S_RDATA = 3'd4;

    logic [7:0]        mem [0:2**ADDR_W-1];
    logic [2:0]        state;
    int                bit_cnt;     // 8 is the ack slot, 9 once its clock was seen
    logic [7:0]        shreg;
    logic [7:0]        rbyte;
    logic [ADDR_W-1:0] word_addr;
    logic              acked;
    logic              drive_low;
    logic              scl_q;
    logic              sda_q;
    ctrl_byte_u        ctrl;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        state     = S_IDLE;
        bit_cnt   = 0;
        acked     = 1'b0;
        drive_low = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = 8'(i ^ (i >> 3));
    end

    task sample_bit();
        if (state != S_IDLE)
        begin
            if (bit_cnt < 8)
            begin
                shreg   = {shreg[6:0], sda === 1'b1};
                bit_cnt = bit_cnt + 1;
            end
            else
                bit_cnt = 9;
        end
    endtask

    task drive_bit();
        if (bit_cnt == 8)
        begin
            case (state)
                S_CTRL:
                begin
                    ctrl.raw = shreg;
                    acked    = ack_en && (ctrl.fields.dev_type == DEV_TYPE);
                end
                S_ADDR:
                begin
                    word_addr = {ctrl.fields.block, shreg};
                    acked     = ack_en;
                end
                S_WDATA:
                begin
                    acked = ack_en;
                    if (acked)
                        mem[word_addr] = shreg;   // no internal write cycle
                end
                default: acked = 1'b0;   // master acks read data
            endcase
            drive_low = acked;
        end
        else if (bit_cnt == 9)
        begin
            drive_low = 1'b0;
            bit_cnt   = 0;
            if (!acked)
                state = S_IDLE;
            else if (state == S_CTRL)
                state = ctrl.fields.rw ? S_RDATA : S_ADDR;
            else if (state == S_ADDR)
                state = S_WDATA;
            else
                state = S_IDLE;
            rbyte = mem[word_addr];
        end
        if (state == S_RDATA && bit_cnt < 8)
            drive_low = !rbyte[7 - bit_cnt];
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1)
        begin
            if (sda !== sda_q)
            begin
                drive_low = 1'b0;
                bit_cnt   = 0;
                state     = (sda === 1'b0) ? S_CTRL : S_IDLE;   // start or stop
            end
        end
        else if (scl === 1'b1)
            sample_bit();
        else if (scl_q === 1'b1)
            drive_bit();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== test/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int                CLK_DIV    = 2;
    localparam int                NUM_TXN    = 41;
    localparam int                TXN_LIMIT  = 2 * 50 * 4 * CLK_DIV;   // cycles
    localparam longint            RUN_NS     = longint'(NUM_TXN) * 50 * 4 * CLK_DIV * 20;
    localparam longint            WATCHDOG_NS = RUN_NS + RUN_NS / 4;
    localparam logic [ADDR_W-1:0] FIXED_ADDR = 11'h2a5;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              ack_en;
    wire  [7:0]        rdata;
    wire               done;
    wire               err;
    wire               busy;
    wire               scl;
    wire               sda;

    logic [31:0] lfsr;
    logic [7:0]  shadow [0:2**ADDR_W-1];
    int          test_errs;
    int          n_pass;
    int          n_fail;
    int          n_done;
    logic        got_done;
    logic        last_err;
    logic [7:0]  last_read;   // byte of the last good read
    logic [7:0]  rdata_after_fail;

    pullup (sda);

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) UUT (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .busy  (busy),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model slave (
        .scl    (scl),
        .sda    (sda),
        .ack_en (ack_en)
    );

    always #10 CLK = ~CLK;

    always @(negedge CLK)
    begin
        if (done === 1'b1)
            n_done++;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic value_error(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        test_errs++;
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0)
        begin
            $display("%s: passed", name);
            n_pass++;
        end
        else
        begin
            $display("%s: failed with %0d errors", name, test_errs);
            n_fail++;
        end
        test_errs = 0;
    endtask

    // one cycle strobe from a falling edge
    task automatic strobe(input logic is_wr, input logic [ADDR_W-1:0] a, input logic [7:0] d);
        wr    = is_wr;
        rd    = !is_wr;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (done !== 1'b1 && n < TXN_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        got_done = (done === 1'b1);
        last_err = err;
        if (!got_done)
        begin
            $display("%s: the DUT gave no done pulse within %0d cycles", name, TXN_LIMIT);
            test_errs++;
        end
    endtask

    task automatic write_byte(input string name, input logic [ADDR_W-1:0] a,
                              input logic [7:0] d);
        strobe(1'b1, a, d);
        wait_done(name);
        if (got_done && last_err !== 1'b0)
            value_error({name, " err"}, 8'd0, last_err);
        shadow[a] = d;
    endtask

    task automatic read_check(input string name, input logic [ADDR_W-1:0] a);
        strobe(1'b0, a, 8'h00);
        wait_done(name);
        if (got_done && last_err !== 1'b0)
            value_error({name, " err"}, 8'd0, last_err);
        if (got_done && rdata !== shadow[a])
            value_error(name, shadow[a], rdata);
        last_read = shadow[a];
    endtask

    task automatic lines_released(input string name);
        if (scl !== 1'b1)
            value_error({name, " scl"}, 8'd1, scl);
        if (sda !== 1'b1)
            value_error({name, " sda"}, 8'd1, sda);
    endtask

    task automatic test_reset_state();
        if (busy !== 1'b0)
            value_error("reset_state busy", 8'd0, busy);
        if (done !== 1'b0)
            value_error("reset_state done", 8'd0, done);
        if (err !== 1'b0)
            value_error("reset_state err", 8'd0, err);
        lines_released("reset_state");
    endtask

    task automatic test_write_read();
        write_byte("write_read", FIXED_ADDR, 8'h3c);
        read_check("write_read", FIXED_ADDR);
    endtask

    task automatic test_random_blocks();
        logic [ADDR_W-1:0] addrs [16];
        logic [31:0]       r;
        for (int i = 0; i < 16; i++)
        begin
            take_bits(8, r);
            addrs[i] = {3'(i), r[7:0]};   // each block twice
            take_bits(8, r);
            write_byte("random_blocks", addrs[i], r[7:0]);
        end
        for (int i = 15; i >= 0; i--)
            read_check("random_blocks", addrs[i]);
    endtask

    task automatic test_busy_strobe();
        logic [31:0]       r;
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        int                done_before;
        take_bits(11, r);
        a1 = r[ADDR_W-1:0];
        a2 = a1 ^ 11'h400;
        write_byte("busy_strobe", a2, 8'h5a);
        @(negedge CLK);
        done_before = n_done;
        strobe(1'b1, a1, 8'hc3);
        if (busy !== 1'b1)
            value_error("busy_strobe busy", 8'd1, busy);
        strobe(1'b1, a2, 8'ha5);   // lands while busy
        wait_done("busy_strobe");
        shadow[a1] = 8'hc3;
        repeat (2) @(negedge CLK);
        if (n_done - done_before != 1)
            value_error("busy_strobe done count", 8'd1, 8'(n_done - done_before));
        read_check("busy_strobe", a2);
        read_check("busy_strobe", a1);
    endtask

    task automatic test_no_ack();
        ack_en = 1'b0;
        strobe(1'b1, FIXED_ADDR, ~shadow[FIXED_ADDR]);
        wait_done("no_ack write");
        if (got_done && last_err !== 1'b1)
            value_error("no_ack write err", 8'd1, last_err);
        if (busy !== 1'b0)
            value_error("no_ack write busy", 8'd0, busy);
        lines_released("no_ack write");
        strobe(1'b0, FIXED_ADDR, 8'h00);
        wait_done("no_ack read");
        if (got_done && last_err !== 1'b1)
            value_error("no_ack read err", 8'd1, last_err);
        if (busy !== 1'b0)
            value_error("no_ack read busy", 8'd0, busy);
        lines_released("no_ack read");
        rdata_after_fail = rdata;
    endtask

    task automatic test_error_recovery();
        ack_en = 1'b1;
        if (rdata_after_fail !== last_read)
            value_error("error_recovery rdata", last_read, rdata_after_fail);
        read_check("error_recovery", FIXED_ADDR);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: the run timed out after %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        CLK       = 1'b0;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = 8'h00;
        ack_en    = 1'b1;
        lfsr      = 32'h66e06b42;
        test_errs = 0;
        n_pass    = 0;
        n_fail    = 0;
        n_done    = 0;
        repeat (8) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        test_reset_state();
        end_test("reset_state");
        test_write_read();
        end_test("write_read");
        test_random_blocks();
        end_test("random_blocks");
        test_busy_strobe();
        end_test("busy_strobe");
        test_no_ack();
        end_test("no_ack");
        test_error_recovery();
        end_test("error_recovery");
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/eeprom_pkg.sv
logic/i2c_byte_if.sv
logic/i2c_bit_if.sv
logic/eeprom_sequencer.sv
logic/i2c_byte_engine.sv
logic/i2c_line_phy.sv
logic/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv
